// File: design/bpu_params.svh
// Branch prediction unit parameters.
// Sizes of the fetch address and of the prediction tables,
// and the fetch address after reset.

`ifndef BPU_PARAMS_SVH
`define BPU_PARAMS_SVH

//////////////////////////////
// Address sizing
//////////////////////////////
`define BPU_PC_WIDTH 16 // 16-bit fetch address.

// Index taken from PC bits 3:1, so 8 entries.
`define BPU_INDEX_BITS 3

//////////////////////////////
// Reset state
//////////////////////////////
`define BPU_RESET_PC 16'h0000 // First fetch address.

`endif // BPU_PARAMS_SVH

// File: design/bpu_pkg.sv
// Branch prediction unit types.
// Fetch address, table index, BTB tag and the 2-bit counter state.

`include "bpu_params.svh"

package bpu_pkg;

  // Tag is the PC above the index, bit 0 is always zero.
  localparam int TAG_BITS = `BPU_PC_WIDTH - `BPU_INDEX_BITS - 1;

  typedef logic [`BPU_PC_WIDTH-1:0]   pc_t;    // Fetch address.
  typedef logic [`BPU_INDEX_BITS-1:0] index_t; // Table index, PC bits 3:1.
  typedef logic [TAG_BITS-1:0]        tag_t;   // BTB tag, 12 bits.

  //////////////////////////////
  // Saturating counter states
  //////////////////////////////
  // Upper bit set means predict taken.
  typedef enum logic [1:0] {
    strong_not_taken = 2'd0,
    weak_not_taken   = 2'd1,
    weak_taken       = 2'd2,
    strong_taken     = 2'd3
  } counter_t;

endpackage

// File: design/bht.sv
// Branch history table.
// 8 entries of 2-bit saturating counters, read combinationally
// at the fetch index and written at the resolve index.

`timescale 1ns/100ps

`include "bpu_params.svh"

module bht (
  input  logic              clk,
  input  logic              rst,
  input  bpu_pkg::index_t   lookup_index,   // Index of the fetch PC.
  output bpu_pkg::counter_t lookup_counter, // Counter for the fetch PC.
  input  logic              update_en,      // Resolve of a branch in IF/ID.
  input  bpu_pkg::index_t   update_index,   // Index of the IF/ID PC.
  input  bpu_pkg::counter_t update_counter  // New state for that entry.
);

  localparam int ENTRIES = 1 << `BPU_INDEX_BITS; // 8 counters.

  //////////////////////////////
  // Counter storage
  //////////////////////////////
  bpu_pkg::counter_t counters [ENTRIES];

  // Every entry starts at strong not taken, so a cold
  // branch falls through until it has been taken twice.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ENTRIES; i++) begin
        counters[i] <= bpu_pkg::strong_not_taken;
      end
    end else if (update_en) begin
      counters[update_index] <= update_counter; // Step toward the outcome.
    end
  end

  //////////////////////////////
  // Lookup
  //////////////////////////////
  // Asynchronous read.
  // A write in the same cycle lands at the edge, so the
  // lookup still returns the old state here.
  assign lookup_counter = counters[lookup_index];

endmodule

// File: design/btb.sv
// Branch target buffer.
// 8 entries, each holding a tag, a target and a valid bit.
// Lookup splits the fetch PC into index and tag and reports a hit
// only on a valid entry with a matching tag.

`timescale 1ns/100ps

`include "bpu_params.svh"

module btb (
  input  logic         clk,
  input  logic         rst,
  input  bpu_pkg::pc_t lookup_pc, // Fetch PC.
  output logic         hit,       // Valid entry, tag matches.
  output bpu_pkg::pc_t target,    // Stored target of that entry.
  input  logic         wen,       // Taken branch resolved.
  input  bpu_pkg::pc_t waddr_pc,  // PC of the resolved branch.
  input  bpu_pkg::pc_t wtarget    // Its actual target.
);

  localparam int ENTRIES = 1 << `BPU_INDEX_BITS; // 8 entries.

  //////////////////////////////
  // Storage
  //////////////////////////////
  bpu_pkg::tag_t tag_mem    [ENTRIES];
  bpu_pkg::pc_t  target_mem [ENTRIES];
  logic [ENTRIES-1:0] valid;             // Only the valid bits reset.

  //////////////////////////////
  // Address split
  //////////////////////////////
  bpu_pkg::index_t lookup_index;
  bpu_pkg::tag_t   lookup_tag;
  bpu_pkg::index_t write_index;
  bpu_pkg::tag_t   write_tag;

  assign lookup_index = lookup_pc[`BPU_INDEX_BITS:1];               // Bit 0 unused.
  assign lookup_tag   = lookup_pc[`BPU_PC_WIDTH-1:`BPU_INDEX_BITS+1];
  assign write_index  = waddr_pc[`BPU_INDEX_BITS:1];
  assign write_tag    = waddr_pc[`BPU_PC_WIDTH-1:`BPU_INDEX_BITS+1];

  //////////////////////////////
  // Write port
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0; // All entries empty.
    end else if (wen) begin
      valid[write_index] <= 1'b1;
    end
  end

  // Tag and target payload.
  always_ff @(posedge clk) begin
    if (wen) begin
      tag_mem[write_index]    <= write_tag;
      target_mem[write_index] <= wtarget;
    end
  end

  //////////////////////////////
  // Lookup
  //////////////////////////////
  // Combinational, sees the old contents during a write.
  assign hit    = valid[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
  assign target = target_mem[lookup_index];

endmodule

// File: design/fetch_pc.sv
// Fetch PC register.
// Picks the next fetch address each cycle: the corrected PC on
// a redirect, the predicted PC when not stalled, else holds.

`timescale 1ns/100ps

`include "bpu_params.svh"

module fetch_pc (
  input  logic         clk,
  input  logic         rst,
  input  logic         stall,        // Front end frozen.
  input  logic         redirect,     // Mispredict in decode.
  input  bpu_pkg::pc_t correct_pc,   // Resolved next address.
  input  bpu_pkg::pc_t predicted_pc, // Predicted next address.
  output bpu_pkg::pc_t pc            // Current fetch address.
);

  //////////////////////////////
  // Next PC select
  //////////////////////////////
  bpu_pkg::pc_t pc_next;

  always_comb begin
    if (redirect) begin
      pc_next = correct_pc;   // Misprediction wins.
    end else if (!stall) begin
      pc_next = predicted_pc; // Normal advance.
    end else begin
      pc_next = pc;           // Hold under back-pressure.
    end
  end

  //////////////////////////////
  // PC register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `BPU_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// File: design/bpu_ctrl.sv
// Branch prediction controller.
// Forms the fetch prediction, keeps the IF/ID prediction record,
// checks it against the decode resolve and drives the table
// updates and the fetch redirect.

`timescale 1ns/100ps

`include "bpu_params.svh"

module bpu_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  logic              stall,
  input  logic              resolve_valid,  // IF/ID holds a branch.
  input  logic              actual_taken,
  input  bpu_pkg::pc_t      actual_target,
  input  bpu_pkg::pc_t      pc,             // Fetch PC.
  input  bpu_pkg::counter_t lookup_counter, // BHT state for pc.
  input  logic              btb_hit,
  input  bpu_pkg::pc_t      btb_target,
  output logic              predict_taken,
  output bpu_pkg::pc_t      predicted_pc,
  output logic              redirect,
  output bpu_pkg::pc_t      correct_pc,
  output logic              update_en,
  output bpu_pkg::index_t   update_index,
  output bpu_pkg::counter_t update_counter,
  output logic              btb_wen,
  output bpu_pkg::tag_t     btb_wtag,
  output bpu_pkg::pc_t      btb_wtarget
);

  localparam bpu_pkg::pc_t INSTR_BYTES = bpu_pkg::pc_t'(2); // 16-bit instructions.

  //////////////////////////////
  // Fetch prediction
  //////////////////////////////
  // Taken only if the counter says so and a target is known.
  assign predict_taken = lookup_counter[1] && btb_hit;
  assign predicted_pc  = predict_taken ? btb_target : pc + INSTR_BYTES;

  //////////////////////////////
  // IF/ID prediction record
  //////////////////////////////
  logic              ifid_valid;
  bpu_pkg::pc_t      ifid_pc;
  bpu_pkg::counter_t ifid_counter;
  logic              ifid_taken;
  bpu_pkg::pc_t      ifid_target;  // Target used if predicted taken.
  logic              resolve;

  always_ff @(posedge clk) begin
    if (rst) begin
      ifid_valid <= 1'b0;
    end else if (redirect) begin
      ifid_valid <= 1'b0;          // Wrong-path fetch is squashed.
    end else if (!stall) begin
      ifid_valid <= 1'b1;
    end
  end

  // Payload, no reset.
  always_ff @(posedge clk) begin
    if (!stall) begin
      ifid_pc      <= pc;
      ifid_counter <= lookup_counter;
      ifid_taken   <= predict_taken;
      ifid_target  <= btb_target;
    end
  end

  //////////////////////////////
  // Resolve and mispredict
  //////////////////////////////
  // Decode holds a resolve while stalled, so it only counts here when free.
  assign resolve = resolve_valid && ifid_valid && !stall;

  // Wrong direction, or right direction with a stale target.
  assign redirect = resolve &&
                    ((ifid_taken != actual_taken) ||
                     (ifid_taken && (ifid_target != actual_target)));
  assign correct_pc = actual_taken ? actual_target : ifid_pc + INSTR_BYTES;

  //////////////////////////////
  // Table updates
  //////////////////////////////
  // One step toward the outcome, saturating at both ends.
  always_comb begin
    case (ifid_counter)
      bpu_pkg::strong_not_taken:
        update_counter = actual_taken ? bpu_pkg::weak_not_taken : bpu_pkg::strong_not_taken;
      bpu_pkg::weak_not_taken:
        update_counter = actual_taken ? bpu_pkg::weak_taken : bpu_pkg::strong_not_taken;
      bpu_pkg::weak_taken:
        update_counter = actual_taken ? bpu_pkg::strong_taken : bpu_pkg::weak_not_taken;
      bpu_pkg::strong_taken:
        update_counter = actual_taken ? bpu_pkg::strong_taken : bpu_pkg::weak_taken;
      default:
        update_counter = bpu_pkg::strong_not_taken;
    endcase
  end

  assign update_en    = resolve;                          // Every resolve trains the BHT.
  assign update_index = ifid_pc[`BPU_INDEX_BITS:1];
  assign btb_wen      = resolve && actual_taken;          // Only taken branches fill the BTB.
  assign btb_wtag     = ifid_pc[`BPU_PC_WIDTH-1:`BPU_INDEX_BITS+1];
  assign btb_wtarget  = actual_target;

endmodule

// File: design/bpu_top.sv
// Branch prediction and fetch-address unit.
// Fetch PC, BHT and BTB lookups, and the controller that checks
// predictions against the decode resolve.

`timescale 1ns/100ps

`include "bpu_params.svh"

module bpu_top (
  input  logic         clk,
  input  logic         rst,
  input  logic         stall,         // Back-pressure from the pipeline.
  input  logic         resolve_valid, // Decode resolved a branch.
  input  logic         actual_taken,
  input  bpu_pkg::pc_t actual_target,
  output bpu_pkg::pc_t pc,            // Fetch address.
  output logic         predict_taken, // Prediction for pc.
  output logic         redirect       // Mispredict, refetch from corrected PC.
);

  //////////////////////////////
  // Internal wires
  //////////////////////////////
  bpu_pkg::counter_t lookup_counter;
  logic              btb_hit;
  bpu_pkg::pc_t      btb_target;
  bpu_pkg::pc_t      predicted_pc;
  bpu_pkg::pc_t      correct_pc;
  logic              update_en;
  bpu_pkg::index_t   update_index;
  bpu_pkg::counter_t update_counter;
  logic              btb_wen;
  bpu_pkg::tag_t     btb_wtag;
  bpu_pkg::pc_t      btb_wtarget;

  bpu_ctrl u_ctrl (
    .clk, .rst, .stall, .resolve_valid, .actual_taken, .actual_target,
    .pc, .lookup_counter, .btb_hit, .btb_target,
    .predict_taken, .predicted_pc, .redirect, .correct_pc,
    .update_en, .update_index, .update_counter,
    .btb_wen, .btb_wtag, .btb_wtarget
  );

  fetch_pc u_fetch_pc (
    .clk, .rst, .stall, .redirect, .correct_pc, .predicted_pc, .pc
  );

  bht u_bht (
    .clk, .rst,
    .lookup_index   (pc[`BPU_INDEX_BITS:1]), // Same index bits as the BTB.
    .lookup_counter,
    .update_en, .update_index, .update_counter
  );

  // Write address rebuilt from the IF/ID tag and index, bit 0 is zero.
  btb u_btb (
    .clk, .rst,
    .lookup_pc (pc),
    .hit       (btb_hit),
    .target    (btb_target),
    .wen       (btb_wen),
    .waddr_pc  ({btb_wtag, update_index, 1'b0}),
    .wtarget   (btb_wtarget)
  );

endmodule

// File: verification/bpu_tb.sv
// Testbench for the branch prediction unit.
// Directed tests against a reference model of the BHT, BTB,
// IF/ID record and fetch PC that is checked every cycle.

`timescale 1ns/100ps

`include "bpu_params.svh"

module bpu_tb;

  logic         clk;
  logic         rst;
  logic         stall;
  logic         resolve_valid;
  logic         actual_taken;
  bpu_pkg::pc_t actual_target;
  bpu_pkg::pc_t pc;
  logic         predict_taken;
  logic         redirect;

  bpu_top dut (
    .clk, .rst, .stall, .resolve_valid, .actual_taken, .actual_target,
    .pc, .predict_taken, .redirect
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period.
  end

  //////////////////////////////
  // Reference model state
  //////////////////////////////
  logic [1:0]   model_count  [8]; // Saturating counter per entry.
  logic         model_valid  [8];
  logic [11:0]  model_tag    [8];
  bpu_pkg::pc_t model_target [8];
  bpu_pkg::pc_t model_pc;
  logic         model_ifid_valid;
  bpu_pkg::pc_t model_ifid_pc;
  logic         model_ifid_taken;
  bpu_pkg::pc_t model_ifid_target;

  bpu_pkg::pc_t seen_pc;       // Outputs sampled in the last cycle.
  logic         seen_taken;
  logic         seen_redirect;

  string        test_name;
  int           checks;
  int           errors;
  bpu_pkg::pc_t addr_a;        // Trained branch.
  bpu_pkg::pc_t addr_t;        // Its target.
  bpu_pkg::pc_t addr_b;        // Same index as A, other tag.

  function automatic logic [2:0] index_of(input bpu_pkg::pc_t p);
    return p[`BPU_INDEX_BITS:1];
  endfunction

  function automatic logic [11:0] tag_of(input bpu_pkg::pc_t p);
    return p[`BPU_PC_WIDTH-1:`BPU_INDEX_BITS+1];
  endfunction

  // Taken needs the counter upper bit and a valid BTB entry with matching tag.
  function automatic logic model_predicts(input bpu_pkg::pc_t p);
    logic [2:0] i;
    i = index_of(p);
    return model_count[i][1] && model_valid[i] && (model_tag[i] == tag_of(p));
  endfunction

  function automatic logic [1:0] saturate_step(input logic [1:0] c, input logic taken);
    if (taken) begin
      return (c == 2'd3) ? 2'd3 : c + 2'd1;
    end
    return (c == 2'd0) ? 2'd0 : c - 2'd1;
  endfunction

  task automatic clear_model;
    for (int i = 0; i < 8; i++) begin
      model_count[i]  = 2'd0;
      model_valid[i]  = 1'b0;
      model_tag[i]    = 12'h000;
      model_target[i] = 16'h0000;
    end
    model_pc          = `BPU_RESET_PC;
    model_ifid_valid  = 1'b0;
    model_ifid_pc     = 16'h0000;
    model_ifid_taken  = 1'b0;
    model_ifid_target = 16'h0000;
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////
  task automatic check_value(input string what, input bpu_pkg::pc_t expected,
                             input bpu_pkg::pc_t actual);
    checks = checks + 1;
    assert (actual === expected) else begin
      $display("Error %s: %s expected %h, actual %h", test_name, what, expected, actual);
      errors = errors + 1;
    end
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    checks = checks + 1;
    assert (actual === expected) else begin
      $display("Error %s: %s expected %b, actual %b", test_name, what, expected, actual);
      errors = errors + 1;
    end
  endtask

  //////////////////////////////
  // Cycle driver and model step
  //////////////////////////////
  // Entered at a rising edge. Drives, samples at the falling edge,
  // then steps the model across the closing edge.
  task automatic run_cycle(input logic stall_in, input logic resolve_in,
                           input logic taken_in, input bpu_pkg::pc_t target_in);
    logic         exp_taken;
    logic         exp_resolve;
    logic         exp_redirect;
    bpu_pkg::pc_t fetch_target;
    bpu_pkg::pc_t exp_next;
    bpu_pkg::pc_t exp_correct;
    logic [2:0]   i;
    stall         <= stall_in;
    resolve_valid <= resolve_in;
    actual_taken  <= taken_in;
    actual_target <= target_in;
    @(negedge clk);
    seen_pc       = pc;
    seen_taken    = predict_taken;
    seen_redirect = redirect;
    exp_taken     = model_predicts(model_pc);
    fetch_target  = model_target[index_of(model_pc)]; // Old contents.
    exp_next      = exp_taken ? fetch_target : model_pc + 16'd2;
    exp_resolve   = resolve_in && model_ifid_valid && !stall_in; // Held while stalled.
    exp_redirect  = exp_resolve && ((model_ifid_taken != taken_in) ||
                    (model_ifid_taken && (model_ifid_target != target_in)));
    exp_correct   = taken_in ? target_in : model_ifid_pc + 16'd2;
    check_value("pc", model_pc, seen_pc);
    check_flag("predict_taken", exp_taken, seen_taken);
    check_flag("redirect", exp_redirect, seen_redirect);
    if (exp_resolve) begin
      i = index_of(model_ifid_pc);
      model_count[i] = saturate_step(model_count[i], taken_in);
      if (taken_in) begin
        model_valid[i]  = 1'b1;
        model_tag[i]    = tag_of(model_ifid_pc);
        model_target[i] = target_in;
      end
    end
    if (!stall_in) begin
      model_ifid_pc     = model_pc;
      model_ifid_taken  = exp_taken;
      model_ifid_target = fetch_target;
      model_ifid_valid  = !exp_redirect; // Wrong-path fetch squashed.
    end
    model_pc = exp_redirect ? exp_correct : (stall_in ? model_pc : exp_next);
    @(posedge clk);
  endtask

  task automatic wait_for_pc(input bpu_pkg::pc_t target);
    int   n;
    logic found;
    n     = 0;
    found = 1'b0;
    while (!found && n < 50) begin
      run_cycle(1'b0, 1'b0, 1'b0, 16'h0000);
      found = (seen_pc == target);
      n = n + 1;
    end
    if (!found) begin
      $display("Timed out after 50 cycles in %s waiting for pc %h", test_name, target);
      errors = errors + 1;
    end
  endtask

  // Resolve the IF/ID entry as taken to the wanted address.
  // Returns with that address just captured into IF/ID.
  task automatic steer_fetch(input bpu_pkg::pc_t target);
    if (!model_ifid_valid) begin
      run_cycle(1'b0, 1'b0, 1'b0, 16'h0000); // Let a valid entry reach IF/ID.
    end
    run_cycle(1'b0, 1'b1, 1'b1, target);
    if (seen_redirect || seen_pc != target) begin
      wait_for_pc(target);
    end
  endtask

  // Index of A kept clear of the entries that steering trains.
  task automatic pick_addresses;
    logic [2:0]  idx_a;
    logic [11:0] tag_a;
    logic [11:0] tag_t;
    logic [11:0] tag_flip;
    idx_a    = 3'(4 + ($urandom % 4));
    tag_a    = 12'($urandom);
    tag_t    = 12'($urandom);
    tag_flip = 12'(1 + ($urandom % 4095)); // Never zero.
    addr_a   = {tag_a, idx_a, 1'b0};
    addr_t   = {tag_t, idx_a ^ 3'd4, 1'b0};
    addr_b   = {tag_a ^ tag_flip, idx_a, 1'b0};
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic reset_and_advance;
    test_name = "reset_and_advance";
    for (int i = 0; i < 4; i++) begin
      run_cycle(1'b0, 1'b0, 1'b0, 16'h0000);
      check_value("sequential pc", 16'(`BPU_RESET_PC + 2 * i), seen_pc);
      check_flag("predict_taken after reset", 1'b0, seen_taken);
      check_flag("redirect after reset", 1'b0, seen_redirect);
    end
  endtask

  task automatic train_taken_branch;
    test_name = "train_taken_branch";
    repeat (2) begin
      steer_fetch(addr_a);
      run_cycle(1'b0, 1'b1, 1'b1, addr_t); // A taken to T.
    end
    steer_fetch(addr_a);
    check_flag("predict_taken at A", 1'b1, seen_taken);
    run_cycle(1'b0, 1'b1, 1'b1, addr_t);   // Predicted right, so A goes strong.
    check_value("pc after A", addr_t, seen_pc);
    check_flag("redirect on correct prediction", 1'b0, seen_redirect);
  endtask

  task automatic alias_miss;
    test_name = "alias_miss";
    steer_fetch(addr_b);
    check_flag("predict_taken at alias", 1'b0, seen_taken);
    run_cycle(1'b0, 1'b0, 1'b0, 16'h0000); // B stays unresolved.
    check_value("pc after alias", addr_b + 16'd2, seen_pc);
  endtask

  task automatic mispredict_hysteresis;
    test_name = "mispredict_hysteresis";
    steer_fetch(addr_a);
    check_flag("predict_taken at strong_taken", 1'b1, seen_taken);
    run_cycle(1'b0, 1'b1, 1'b0, 16'h0000);
    check_flag("redirect on not-taken", 1'b1, seen_redirect);
    run_cycle(1'b0, 1'b0, 1'b0, 16'h0000);
    check_value("pc after redirect", addr_a + 16'd2, seen_pc);
    steer_fetch(addr_a);
    check_flag("predict_taken after one not-taken", 1'b1, seen_taken);
    run_cycle(1'b0, 1'b1, 1'b0, 16'h0000);
    check_flag("redirect on second not-taken", 1'b1, seen_redirect);
    steer_fetch(addr_a);
    check_flag("predict_taken after two not-taken", 1'b0, seen_taken);
  endtask

  // IF/ID holds A here. Accepting the resolve would flip its counter.
  task automatic stall_hold;
    bpu_pkg::pc_t held_pc;
    test_name = "stall_hold";
    held_pc   = addr_a + 16'd2; // A was predicted not taken so fetch sits at A + 2.
    repeat (4) begin
      run_cycle(1'b1, 1'b1, 1'b1, addr_t);
      check_value("pc under stall", held_pc, seen_pc);
      check_flag("redirect under stall", 1'b0, seen_redirect);
    end
    run_cycle(1'b0, 1'b0, 1'b0, 16'h0000);
    check_value("pc after stall", held_pc, seen_pc);
    steer_fetch(addr_a);
    check_flag("predict_taken after stall", 1'b0, seen_taken);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    void'($urandom(32'h5c6c));
    rst           = 1'b1;
    stall         = 1'b0;
    resolve_valid = 1'b0;
    actual_taken  = 1'b0;
    actual_target = 16'h0000;
    checks        = 0;
    errors        = 0;
    test_name     = "setup";
    clear_model();
    pick_addresses();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    reset_and_advance();
    train_taken_branch();
    alias_miss();
    mispredict_hysteresis();
    stall_hold();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+design
design/bpu_pkg.sv
design/bht.sv
design/btb.sv
design/fetch_pc.sv
design/bpu_ctrl.sv
design/bpu_top.sv
verification/bpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the branch prediction unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module bpu_tb -f all.f \
  && ./obj_dir/Vbpu_tb | tee /dev/stderr | grep -x "all tests passed" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
